/* hw/cu_control_fsm.sv */
////////////////////
// control sequencer: idle, configured, running, done
// a zero configuration word is ignored, a nonzero one overwrites the latch
// done is sticky until reset
////////////////////

`timescale 1ns/10ps
`default_nettype none

module cu_control_fsm (
	input  logic                 clock,
	input  logic                 rstn,
	input  logic                 enabled,
	input  cu_pkg::cu_config_t   config_word,
	input  logic                 wed_valid,
	input  logic                 count_match,
	output cu_pkg::ctrl_state_t  state,
	output logic                 running,
	output logic                 done,
	output cu_pkg::cu_config_t   cu_status
);

	cu_pkg::ctrl_state_t state_next;
	logic                config_set;

	assign config_set = enabled && (|config_word);

	////////////////////
	// next state
	////////////////////

	always_comb begin
		state_next = state;
		case (state)
			cu_pkg::ST_IDLE: begin
				if (config_set)
					state_next = cu_pkg::ST_CONFIGURED;
			end
			cu_pkg::ST_CONFIGURED: begin
				// descriptor arrival starts the unit
				if (enabled && wed_valid)
					state_next = cu_pkg::ST_RUNNING;
			end
			cu_pkg::ST_RUNNING: begin
				if (count_match)
					state_next = cu_pkg::ST_DONE;
			end
			default: begin
				state_next = state;
			end
		endcase
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state     <= cu_pkg::ST_IDLE;
			cu_status <= '0;
		end else begin
			state <= state_next;
			if (config_set)
				cu_status <= config_word;
		end
	end

	assign running = (state == cu_pkg::ST_RUNNING);
	assign done    = (state == cu_pkg::ST_DONE);

	// completion is only reachable from the running state
	done_from_running: assert property (@(posedge clock) disable iff (!rstn)
		$rose(done) |-> $past(state) == cu_pkg::ST_RUNNING);

endmodule

`default_nettype wire

/* hw/cu_control_top.sv */
////////////////////
// control block of the graph compute unit
// every input except the read command requests passes one register stage
// descriptor totals are latched once, when the unit starts
////////////////////

`timescale 1ns/10ps
`default_nettype none

module cu_control_top (
	input  logic                  clock,
	input  logic                  rstn,
	input  logic                  enabled,
	input  cu_pkg::cu_config_t    cu_configure,
	input  logic                  wed_valid,
	input  cu_pkg::vertex_count_t wed_num_vertices,
	input  cu_pkg::edge_count_t   wed_num_edges,
	input  logic                  resp_valid,
	input  cu_pkg::cu_id_t        resp_id,
	input  cu_pkg::resp_payload_t resp_payload,
	input  logic                  vertex_done_pulse,
	input  logic                  vertex_skip_pulse,
	input  logic                  edge_done_pulse,
	input  logic                  read_buffer_alfull,
	input  logic                  job_request,
	input  cu_pkg::read_cmd_t     job_command,
	input  logic                  cluster_request,
	input  cu_pkg::read_cmd_t     cluster_command,
	output logic                  job_grant,
	output logic                  cluster_grant,
	output logic                  read_cmd_valid,
	output cu_pkg::read_cmd_t     read_cmd,
	output logic                  job_resp_valid,
	output logic                  cluster_resp_valid,
	output cu_pkg::resp_payload_t routed_payload,
	output cu_pkg::cu_config_t    cu_status,
	output logic                  cu_done,
	output cu_pkg::vertex_count_t cu_return_vertices,
	output cu_pkg::edge_count_t   cu_return_edges
);

	// input register stage
	logic                  enabled_r;
	cu_pkg::cu_config_t    config_r;
	logic                  wed_valid_r;
	cu_pkg::vertex_count_t wed_vertices_r;
	cu_pkg::edge_count_t   wed_edges_r;
	logic                  resp_valid_r;
	cu_pkg::cu_id_t        resp_id_r;
	cu_pkg::resp_payload_t resp_payload_r;
	logic                  vertex_done_r;
	logic                  vertex_skip_r;
	logic                  edge_done_r;
	logic                  alfull_r;

	// descriptor totals and steering
	cu_pkg::vertex_count_t total_vertices;
	cu_pkg::edge_count_t   total_edges;
	cu_pkg::ctrl_state_t   state;
	logic                  running;
	logic                  unit_active;
	logic                  count_match;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled_r     <= 1'b0;
			config_r      <= '0;
			wed_valid_r   <= 1'b0;
			resp_valid_r  <= 1'b0;
			vertex_done_r <= 1'b0;
			vertex_skip_r <= 1'b0;
			edge_done_r   <= 1'b0;
			alfull_r      <= 1'b0;
		end else begin
			enabled_r     <= enabled;
			config_r      <= cu_configure;
			wed_valid_r   <= wed_valid;
			resp_valid_r  <= resp_valid;
			vertex_done_r <= vertex_done_pulse;
			vertex_skip_r <= vertex_skip_pulse;
			edge_done_r   <= edge_done_pulse;
			alfull_r      <= read_buffer_alfull;
		end
	end

	always_ff @(posedge clock) begin
		wed_vertices_r <= wed_num_vertices;
		wed_edges_r    <= wed_num_edges;
		resp_id_r      <= resp_id;
		resp_payload_r <= resp_payload;
	end

	// totals are taken from the descriptor that starts the unit
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			total_vertices <= '0;
			total_edges    <= '0;
		end else if (wed_valid_r && enabled_r && state == cu_pkg::ST_CONFIGURED) begin
			total_vertices <= wed_vertices_r;
			total_edges    <= wed_edges_r;
		end
	end

	assign unit_active = running && enabled_r;

	////////////////////
	// instances
	////////////////////

	cu_control_fsm cu_control_fsm_i (
		.clock       (clock),
		.rstn        (rstn),
		.enabled     (enabled_r),
		.config_word (config_r),
		.wed_valid   (wed_valid_r),
		.count_match (count_match),
		.state       (state),
		.running     (running),
		.done        (cu_done),
		.cu_status   (cu_status)
	);

	cu_job_counter cu_job_counter_i (
		.clock             (clock),
		.rstn              (rstn),
		.count_enable      (unit_active),
		.vertex_done_pulse (vertex_done_r),
		.vertex_skip_pulse (vertex_skip_r),
		.edge_done_pulse   (edge_done_r),
		.total_vertices    (total_vertices),
		.total_edges       (total_edges),
		.vertices_counted  (cu_return_vertices),
		.edges_counted     (cu_return_edges),
		.count_match       (count_match)
	);

	cu_response_router cu_response_router_i (
		.clock              (clock),
		.rstn               (rstn),
		.route_enable       (unit_active),
		.resp_valid         (resp_valid_r),
		.resp_id            (resp_id_r),
		.resp_payload       (resp_payload_r),
		.job_resp_valid     (job_resp_valid),
		.cluster_resp_valid (cluster_resp_valid),
		.routed_payload     (routed_payload)
	);

	cu_read_arbiter cu_read_arbiter_i (
		.clock           (clock),
		.rstn            (rstn),
		.arb_enable      (unit_active),
		.buffer_alfull   (alfull_r),
		.job_request     (job_request),
		.job_command     (job_command),
		.cluster_request (cluster_request),
		.cluster_command (cluster_command),
		.job_grant       (job_grant),
		.cluster_grant   (cluster_grant),
		.read_cmd_valid  (read_cmd_valid),
		.read_cmd        (read_cmd)
	);

endmodule

`default_nettype wire

/* hw/cu_job_counter.sv */
////////////////////
// completion counters for vertices, skipped vertices and edges
// pulses outside count_enable are dropped
// counters wrap silently at full width
////////////////////

`timescale 1ns/10ps
`default_nettype none

module cu_job_counter (
	input  logic                  clock,
	input  logic                  rstn,
	input  logic                  count_enable,
	input  logic                  vertex_done_pulse,
	input  logic                  vertex_skip_pulse,
	input  logic                  edge_done_pulse,
	input  cu_pkg::vertex_count_t total_vertices,
	input  cu_pkg::edge_count_t   total_edges,
	output cu_pkg::vertex_count_t vertices_counted,
	output cu_pkg::edge_count_t   edges_counted,
	output logic                  count_match
);

	cu_pkg::vertex_count_t vertex_done_cnt;
	cu_pkg::vertex_count_t vertex_skip_cnt;
	cu_pkg::edge_count_t   edge_done_cnt;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_done_cnt <= '0;
			vertex_skip_cnt <= '0;
			edge_done_cnt   <= '0;
		end else if (count_enable) begin
			if (vertex_done_pulse)
				vertex_done_cnt <= vertex_done_cnt + 1'b1;
			if (vertex_skip_pulse)
				vertex_skip_cnt <= vertex_skip_cnt + 1'b1;
			if (edge_done_pulse)
				edge_done_cnt <= edge_done_cnt + 1'b1;
		end
	end

	// filtered vertices count as processed
	assign vertices_counted = vertex_done_cnt + vertex_skip_cnt;
	assign edges_counted    = edge_done_cnt;

	// compare one cycle behind the counters
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			count_match <= 1'b0;
		end else begin
			count_match <= count_enable &&
				(vertices_counted == total_vertices) &&
				(edges_counted == total_edges);
		end
	end

endmodule

`default_nettype wire

/* hw/cu_macros.svh */
////////////////////
// widths and ids shared by the compute-unit control block
// the vertex-control id must match the id used by the vertex job side
// only two read command requesters are supported by the arbiter
////////////////////

`ifndef CU_MACROS_SVH
`define CU_MACROS_SVH

// vertex and edge counters
`define CU_VERTEX_W 32
`define CU_EDGE_W 32

// configuration word, echoed as status
`define CU_CONFIG_W 64

// compute-unit id carried in every read response
`define CU_ID_W 8

// read command and response payloads
`define CU_CMD_W 64
`define CU_RESP_W 64

// responses with this id go to the vertex job side
`define CU_VERTEX_CONTROL_ID 8'h01

// job side is requester 0, cluster side is requester 1
`define CU_NUM_READ_REQ 2

`endif

/* hw/cu_pkg.sv */
////////////////////
// types for the compute-unit control block
// widths come from cu_macros.svh
////////////////////

`default_nettype none

`include "cu_macros.svh"

package cu_pkg;

	// counters
	typedef logic [`CU_VERTEX_W-1:0] vertex_count_t;
	typedef logic [`CU_EDGE_W-1:0] edge_count_t;

	// configuration and status word
	typedef logic [`CU_CONFIG_W-1:0] cu_config_t;

	// id of the unit that issued the matching read command
	typedef logic [`CU_ID_W-1:0] cu_id_t;

	// bus payloads
	typedef logic [`CU_CMD_W-1:0] read_cmd_t;
	typedef logic [`CU_RESP_W-1:0] resp_payload_t;

	// control sequencer states
	typedef enum logic [1:0] {
		ST_IDLE       = 2'd0,
		ST_CONFIGURED = 2'd1,
		ST_RUNNING    = 2'd2,
		ST_DONE       = 2'd3
	} ctrl_state_t;

endpackage

`default_nettype wire

/* hw/cu_read_arbiter.sv */
////////////////////
// round-robin arbiter for the two read command requesters
// requesters hold request and command until granted
// no new grant while the read buffer is almost full
////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "cu_macros.svh"

module cu_read_arbiter (
	input  logic              clock,
	input  logic              rstn,
	input  logic              arb_enable,
	input  logic              buffer_alfull,
	input  logic              job_request,
	input  cu_pkg::read_cmd_t job_command,
	input  logic              cluster_request,
	input  cu_pkg::read_cmd_t cluster_command,
	output logic              job_grant,
	output logic              cluster_grant,
	output logic              read_cmd_valid,
	output cu_pkg::read_cmd_t read_cmd
);

	// bit 0 is the job side, bit 1 the cluster side
	logic [`CU_NUM_READ_REQ-1:0] request_vec;
	logic [`CU_NUM_READ_REQ-1:0] eligible;
	logic [`CU_NUM_READ_REQ-1:0] grant_next;
	logic [`CU_NUM_READ_REQ-1:0] grant_q;
	// set when the cluster side wins the next tie
	logic                        cluster_first;
	logic                        can_grant;

	assign request_vec = {cluster_request, job_request};
	assign can_grant   = arb_enable && !buffer_alfull;

	// a requester granted last cycle is still dropping its request
	assign eligible = request_vec & ~grant_q & {`CU_NUM_READ_REQ{can_grant}};

	always_comb begin
		grant_next = '0;
		if (eligible[0] && (!eligible[1] || !cluster_first))
			grant_next[0] = 1'b1;
		else if (eligible[1])
			grant_next[1] = 1'b1;
	end

	////////////////////
	// grant and priority
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			grant_q        <= '0;
			cluster_first  <= 1'b0;
			read_cmd_valid <= 1'b0;
		end else begin
			grant_q        <= grant_next;
			read_cmd_valid <= |grant_q;
			if (|grant_next)
				cluster_first <= grant_next[0];
		end
	end

	// command captured while the winner still holds it
	always_ff @(posedge clock) begin
		read_cmd <= grant_q[1] ? cluster_command : job_command;
	end

	assign job_grant     = grant_q[0];
	assign cluster_grant = grant_q[1];

	single_grant: assert property (@(posedge clock) disable iff (!rstn)
		!(job_grant && cluster_grant));

endmodule

`default_nettype wire

/* hw/cu_response_router.sv */
////////////////////
// read response demux, job side or cluster side by id
// one register stage, payload shared by both outputs
// responses outside route_enable are dropped
////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "cu_macros.svh"

module cu_response_router (
	input  logic                  clock,
	input  logic                  rstn,
	input  logic                  route_enable,
	input  logic                  resp_valid,
	input  cu_pkg::cu_id_t        resp_id,
	input  cu_pkg::resp_payload_t resp_payload,
	output logic                  job_resp_valid,
	output logic                  cluster_resp_valid,
	output cu_pkg::resp_payload_t routed_payload
);

	logic take_resp;
	logic to_job;

	assign take_resp = route_enable && resp_valid;
	assign to_job    = (resp_id == `CU_VERTEX_CONTROL_ID);

	////////////////////
	// valid steering
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			job_resp_valid     <= 1'b0;
			cluster_resp_valid <= 1'b0;
		end else begin
			job_resp_valid     <= take_resp && to_job;
			cluster_resp_valid <= take_resp && !to_job;
		end
	end

	// payload follows the valid, qualified downstream
	always_ff @(posedge clock) begin
		routed_payload <= resp_payload;
	end

	// a response goes to exactly one side
	one_side_only: assert property (@(posedge clock) disable iff (!rstn)
		!(job_resp_valid && cluster_resp_valid));

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build and run the control block testbench with Verilator
# exits nonzero when the build, the run or a check fails

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module cu_control_tb \
	-f tb.f --Mdir obj_dir -o cu_control_sim > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "verilator build failed, see build.log"
	exit 1
fi

./obj_dir/cu_control_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
	echo "simulation exited with an error, see sim.log"
	exit 1
fi

if grep -q "Testbench failed" sim.log; then
	echo "simulation reported a failure, see sim.log"
	exit 1
fi

echo "simulation finished without failures"
exit 0

/* tb.f */
+incdir+hw
hw/cu_pkg.sv
hw/cu_control_fsm.sv
hw/cu_job_counter.sv
hw/cu_response_router.sv
hw/cu_read_arbiter.sv
hw/cu_control_top.sv
tests/cu_control_tb.sv

/* tests/cu_control_tb.sv */
////////////////////
// directed testbench for the compute-unit control block
// inputs change on the rising edge and outputs are sampled on the falling edge
// tests run in order and share one descriptor of 5 vertices and 7 edges
////////////////////

`timescale 1ns/10ps
`default_nettype none

module cu_control_tb;

	localparam int CLOCK_HALF = 10;
	localparam int RESET_CYCLES = 8;
	// well above the length of the test sequence
	localparam int TIMEOUT_CYCLES = 3000;
	localparam logic [7:0] JOB_ID = 8'h01;
	localparam int NUM_RESP = 40;

	logic                  clock;
	logic                  rstn;
	logic                  enabled;
	cu_pkg::cu_config_t    cu_configure;
	logic                  wed_valid;
	cu_pkg::vertex_count_t wed_num_vertices;
	cu_pkg::edge_count_t   wed_num_edges;
	logic                  resp_valid;
	cu_pkg::cu_id_t        resp_id;
	cu_pkg::resp_payload_t resp_payload;
	logic                  vertex_done_pulse;
	logic                  vertex_skip_pulse;
	logic                  edge_done_pulse;
	logic                  read_buffer_alfull;
	logic                  job_request;
	cu_pkg::read_cmd_t     job_command;
	logic                  cluster_request;
	cu_pkg::read_cmd_t     cluster_command;
	logic                  job_grant;
	logic                  cluster_grant;
	logic                  read_cmd_valid;
	cu_pkg::read_cmd_t     read_cmd;
	logic                  job_resp_valid;
	logic                  cluster_resp_valid;
	cu_pkg::resp_payload_t routed_payload;
	cu_pkg::cu_config_t    cu_status;
	logic                  cu_done;
	cu_pkg::vertex_count_t cu_return_vertices;
	cu_pkg::edge_count_t   cu_return_edges;

	logic [31:0] lfsr_state;
	int          error_count;
	int          cycle_count = 0;
	// high when the last grant went to the cluster side
	logic        last_cluster;

	cu_control_top cu_control_top_i (
		.clock              (clock),
		.rstn               (rstn),
		.enabled            (enabled),
		.cu_configure       (cu_configure),
		.wed_valid          (wed_valid),
		.wed_num_vertices   (wed_num_vertices),
		.wed_num_edges      (wed_num_edges),
		.resp_valid         (resp_valid),
		.resp_id            (resp_id),
		.resp_payload       (resp_payload),
		.vertex_done_pulse  (vertex_done_pulse),
		.vertex_skip_pulse  (vertex_skip_pulse),
		.edge_done_pulse    (edge_done_pulse),
		.read_buffer_alfull (read_buffer_alfull),
		.job_request        (job_request),
		.job_command        (job_command),
		.cluster_request    (cluster_request),
		.cluster_command    (cluster_command),
		.job_grant          (job_grant),
		.cluster_grant      (cluster_grant),
		.read_cmd_valid     (read_cmd_valid),
		.read_cmd           (read_cmd),
		.job_resp_valid     (job_resp_valid),
		.cluster_resp_valid (cluster_resp_valid),
		.routed_payload     (routed_payload),
		.cu_status          (cu_status),
		.cu_done            (cu_done),
		.cu_return_vertices (cu_return_vertices),
		.cu_return_edges    (cu_return_edges)
	);

	initial clock = 1'b0;
	always #CLOCK_HALF clock = ~clock;

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("error: run stopped by the timeout after %0d cycles", cycle_count);
			$display("Testbench failed");
			$finish;
		end
	end

	////////////////////
	// helpers
	////////////////////

	// fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	task automatic random_bits(input int nbits, output logic [63:0] value);
		value = '0;
		for (int i = 0; i < nbits; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			value = {value[62:0], lfsr_state[0]};
		end
	endtask

	task automatic report_mismatch(input string test_name, input logic [63:0] expected,
			input logic [63:0] actual);
		$display("[FAIL] %s: expected %h, actual %h", test_name, expected, actual);
		error_count++;
	endtask

	task automatic report_problem(input string text);
		$display("error: %s", text);
		error_count++;
	endtask

	// returns on the falling edge where the grant is seen
	task automatic wait_for_grant(input logic cluster_side, input int limit,
			output logic granted);
		int cycles;
		cycles = 0;
		granted = 1'b0;
		while (!granted && cycles < limit) begin
			@(negedge clock);
			cycles++;
			if ((cluster_side ? job_grant : cluster_grant) === 1'b1)
				report_problem("grant given to the side that did not request");
			granted = ((cluster_side ? cluster_grant : job_grant) === 1'b1);
		end
	endtask

	// the requester drops after its grant and the command follows one cycle later
	task automatic finish_request(input logic cluster_side, input logic [63:0] cmd,
			input string test_name);
		@(posedge clock);
		job_request <= 1'b0;
		cluster_request <= 1'b0;
		last_cluster = cluster_side;
		@(negedge clock);
		if (read_cmd_valid !== 1'b1)
			report_mismatch(test_name, 64'd1, 64'(read_cmd_valid));
		if (read_cmd !== cmd)
			report_mismatch(test_name, cmd, read_cmd);
	endtask

	////////////////////
	// tests
	////////////////////

	task automatic check_reset_values();
		@(negedge clock);
		if ({job_grant, cluster_grant, read_cmd_valid, job_resp_valid,
				cluster_resp_valid, cu_done} !== 6'b0)
			report_mismatch("reset outputs", 64'd0, 64'({job_grant, cluster_grant,
				read_cmd_valid, job_resp_valid, cluster_resp_valid, cu_done}));
		if (cu_status !== '0)
			report_mismatch("reset cu_status", 64'd0, cu_status);
		if (cu_return_vertices !== '0)
			report_mismatch("reset vertex count", 64'd0, 64'(cu_return_vertices));
		if (cu_return_edges !== '0)
			report_mismatch("reset edge count", 64'd0, 64'(cu_return_edges));
	endtask

	task automatic test_config_latch();
		logic [63:0] r;
		logic [63:0] word;
		logic        seen;
		random_bits(64, r);
		word = r | 64'h1;
		@(posedge clock);
		cu_configure <= '0;
		repeat (4) @(posedge clock);
		@(negedge clock);
		if (cu_status !== '0)
			report_mismatch("config zero word", 64'd0, cu_status);
		@(posedge clock);
		cu_configure <= word;
		seen = 1'b0;
		for (int i = 0; i < 4 && !seen; i++) begin
			@(negedge clock);
			seen = (cu_status === word);
		end
		if (!seen)
			report_mismatch("config latch", word, cu_status);
		// a later zero word must not clear the latch
		@(posedge clock);
		cu_configure <= '0;
		repeat (4) @(posedge clock);
		@(negedge clock);
		if (cu_status !== word)
			report_mismatch("config hold", word, cu_status);
	endtask

	task automatic test_no_route_idle();
		logic [63:0] r;
		for (int i = 0; i < 8; i++) begin
			random_bits(64, r);
			@(posedge clock);
			resp_valid <= (i < 6);
			resp_id <= i[0] ? JOB_ID : 8'h22;
			resp_payload <= r;
			@(negedge clock);
			if (job_resp_valid !== 1'b0 || cluster_resp_valid !== 1'b0)
				report_problem("response routed before the unit started");
		end
	endtask

	task automatic start_unit(input cu_pkg::vertex_count_t vertices,
			input cu_pkg::edge_count_t edges);
		@(posedge clock);
		wed_valid <= 1'b1;
		wed_num_vertices <= vertices;
		wed_num_edges <= edges;
		@(posedge clock);
		wed_valid <= 1'b0;
		// registered descriptor, then one state step
		repeat (2) @(posedge clock);
	endtask

	task automatic test_response_routing();
		logic                  stim_valid [NUM_RESP];
		cu_pkg::cu_id_t        stim_id [NUM_RESP];
		cu_pkg::resp_payload_t stim_payload [NUM_RESP];
		logic [63:0]           r;
		logic                  exp_job;
		logic                  exp_cluster;
		int                    k;
		for (int i = 0; i < NUM_RESP; i++) begin
			random_bits(2, r);
			stim_valid[i] = |r[1:0];
			random_bits(1, r);
			if (r[0]) begin
				stim_id[i] = JOB_ID;
			end else begin
				random_bits(8, r);
				stim_id[i] = r[7:0];
			end
			random_bits(64, r);
			stim_payload[i] = r;
		end
		for (int i = 0; i < NUM_RESP + 2; i++) begin
			@(posedge clock);
			if (i < NUM_RESP) begin
				resp_valid <= stim_valid[i];
				resp_id <= stim_id[i];
				resp_payload <= stim_payload[i];
			end else begin
				resp_valid <= 1'b0;
			end
			@(negedge clock);
			// each response comes out two cycles after it was driven
			k = i - 2;
			exp_job = (i >= 2) && stim_valid[k] && (stim_id[k] == JOB_ID);
			exp_cluster = (i >= 2) && stim_valid[k] && (stim_id[k] != JOB_ID);
			if (job_resp_valid !== exp_job)
				report_mismatch("routing job side", 64'(exp_job), 64'(job_resp_valid));
			if (cluster_resp_valid !== exp_cluster)
				report_mismatch("routing cluster side", 64'(exp_cluster),
					64'(cluster_resp_valid));
			if ((exp_job || exp_cluster) && routed_payload !== stim_payload[k])
				report_mismatch("routing payload", stim_payload[k], routed_payload);
		end
	endtask

	task automatic request_single(input logic cluster_side, input string test_name);
		logic [63:0] cmd;
		logic        granted;
		random_bits(64, cmd);
		@(posedge clock);
		if (cluster_side) begin
			cluster_request <= 1'b1;
			cluster_command <= cmd;
		end else begin
			job_request <= 1'b1;
			job_command <= cmd;
		end
		wait_for_grant(cluster_side, 4, granted);
		if (granted) begin
			finish_request(cluster_side, cmd, test_name);
		end else begin
			report_problem("no grant for a single read request");
			@(posedge clock);
			job_request <= 1'b0;
			cluster_request <= 1'b0;
		end
	endtask

	task automatic test_alternating_grants();
		logic [63:0] job_cmd;
		logic [63:0] cluster_cmd;
		logic        expect_cluster;
		logic        prev_cluster;
		logic        prev_granted;
		int          grants;
		random_bits(64, job_cmd);
		random_bits(64, cluster_cmd);
		@(posedge clock);
		job_request <= 1'b1;
		job_command <= job_cmd;
		cluster_request <= 1'b1;
		cluster_command <= cluster_cmd;
		expect_cluster = !last_cluster;
		prev_cluster = last_cluster;
		prev_granted = 1'b0;
		grants = 0;
		for (int i = 0; i < 12; i++) begin
			@(negedge clock);
			if (prev_granted && read_cmd !== (prev_cluster ? cluster_cmd : job_cmd))
				report_mismatch("alternating command", prev_cluster ? cluster_cmd : job_cmd,
					read_cmd);
			if (prev_granted && read_cmd_valid !== 1'b1)
				report_mismatch("alternating command valid", 64'd1,
					64'(read_cmd_valid));
			prev_granted = 1'b0;
			if (job_grant === 1'b1 && cluster_grant === 1'b1) begin
				report_problem("both grants high together");
			end else if (job_grant === 1'b1 || cluster_grant === 1'b1) begin
				if (cluster_grant !== expect_cluster)
					report_mismatch("alternating side", 64'(expect_cluster),
						64'(cluster_grant));
				prev_cluster = cluster_grant;
				prev_granted = 1'b1;
				expect_cluster = !cluster_grant;
				grants++;
			end
		end
		if (grants < 5)
			report_problem("too few grants with both sides requesting");
		@(posedge clock);
		job_request <= 1'b0;
		cluster_request <= 1'b0;
		last_cluster = prev_cluster;
		// the edge that drops the requests can still grant
		repeat (2) begin
			@(negedge clock);
			if (job_grant === 1'b1)
				last_cluster = 1'b0;
			if (cluster_grant === 1'b1)
				last_cluster = 1'b1;
		end
	endtask

	task automatic test_almost_full();
		logic [63:0] cmd;
		logic        granted;
		random_bits(64, cmd);
		@(posedge clock);
		read_buffer_alfull <= 1'b1;
		// flag passes the input register first
		repeat (2) @(posedge clock);
		job_request <= 1'b1;
		job_command <= cmd;
		for (int i = 0; i < 10; i++) begin
			@(negedge clock);
			if (job_grant !== 1'b0 || cluster_grant !== 1'b0)
				report_problem("grant given while the read buffer was almost full");
		end
		@(posedge clock);
		read_buffer_alfull <= 1'b0;
		wait_for_grant(1'b0, 6, granted);
		if (granted) begin
			finish_request(1'b0, cmd, "almost full release");
		end else begin
			report_problem("no grant after the almost-full flag dropped");
			@(posedge clock);
			job_request <= 1'b0;
		end
	endtask

	task automatic test_completion();
		logic seen_done;
		// all 7 edges and 3 done vertices first, the vertex total stays short
		for (int i = 0; i < 7; i++) begin
			@(posedge clock);
			edge_done_pulse <= 1'b1;
			vertex_done_pulse <= (i < 3);
			@(negedge clock);
			if (cu_done !== 1'b0)
				report_mismatch("completion early done", 64'd0, 64'(cu_done));
		end
		@(posedge clock);
		edge_done_pulse <= 1'b0;
		vertex_done_pulse <= 1'b0;
		// the edge total alone must not finish the unit
		repeat (6) begin
			@(negedge clock);
			if (cu_done !== 1'b0)
				report_mismatch("completion edges only", 64'd0, 64'(cu_done));
		end
		// two skipped vertices close the vertex total
		for (int i = 0; i < 2; i++) begin
			@(posedge clock);
			vertex_skip_pulse <= 1'b1;
			@(negedge clock);
			if (cu_done !== 1'b0)
				report_mismatch("completion early done", 64'd0, 64'(cu_done));
		end
		@(posedge clock);
		vertex_skip_pulse <= 1'b0;
		seen_done = 1'b0;
		for (int i = 0; i < 4 && !seen_done; i++) begin
			@(negedge clock);
			seen_done = (cu_done === 1'b1);
		end
		if (!seen_done)
			report_problem("cu_done did not rise within 4 cycles of the last pulse");
		if (cu_return_vertices !== 32'd5)
			report_mismatch("completion vertices", 64'd5, 64'(cu_return_vertices));
		if (cu_return_edges !== 32'd7)
			report_mismatch("completion edges", 64'd7, 64'(cu_return_edges));
	endtask

	////////////////////
	// sequence
	////////////////////

	initial begin
		lfsr_state = 32'hfc385d5b;
		error_count = 0;
		last_cluster = 1'b1;
		rstn <= 1'b0;
		enabled <= 1'b1;
		cu_configure <= '0;
		wed_valid <= 1'b0;
		wed_num_vertices <= '0;
		wed_num_edges <= '0;
		resp_valid <= 1'b0;
		resp_id <= '0;
		resp_payload <= '0;
		vertex_done_pulse <= 1'b0;
		vertex_skip_pulse <= 1'b0;
		edge_done_pulse <= 1'b0;
		read_buffer_alfull <= 1'b0;
		job_request <= 1'b0;
		job_command <= '0;
		cluster_request <= 1'b0;
		cluster_command <= '0;
		repeat (RESET_CYCLES) @(posedge clock);
		rstn <= 1'b1;

		check_reset_values();
		test_config_latch();
		test_no_route_idle();
		start_unit(32'd5, 32'd7);
		test_response_routing();
		request_single(1'b0, "single job request");
		request_single(1'b1, "single cluster request");
		test_alternating_grants();
		test_almost_full();
		test_completion();

		@(negedge clock);
		$display("errors: %0d", error_count);
		if (error_count == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
